//--- source/decode_pkg.sv
package decode_pkg;

    // 2RI12 major opcodes, inst[31:22].
    localparam logic [9:0] OP_SLTI  = 10'h008;
    localparam logic [9:0] OP_SLTUI = 10'h009;
    localparam logic [9:0] OP_ADDIW = 10'h00a;
    localparam logic [9:0] OP_ANDI  = 10'h00d;
    localparam logic [9:0] OP_ORI   = 10'h00e;
    localparam logic [9:0] OP_XORI  = 10'h00f;
    localparam logic [9:0] OP_LDB   = 10'h0a0;
    localparam logic [9:0] OP_LDH   = 10'h0a1;
    localparam logic [9:0] OP_LDW   = 10'h0a2;
    localparam logic [9:0] OP_STB   = 10'h0a4;
    localparam logic [9:0] OP_STH   = 10'h0a5;
    localparam logic [9:0] OP_STW   = 10'h0a6;
    localparam logic [9:0] OP_LDBU  = 10'h0a8;
    localparam logic [9:0] OP_LDHU  = 10'h0a9;

    // 3R opcodes, inst[31:15].
    localparam logic [16:0] OP_ADDW = 17'h00020;
    localparam logic [16:0] OP_SUBW = 17'h00022;
    localparam logic [16:0] OP_SLT  = 17'h00024;
    localparam logic [16:0] OP_SLTU = 17'h00025;
    localparam logic [16:0] OP_NOR  = 17'h00028;
    localparam logic [16:0] OP_AND  = 17'h00029;
    localparam logic [16:0] OP_OR   = 17'h0002a;
    localparam logic [16:0] OP_XOR  = 17'h0002b;

    localparam logic [7:0] ALU_NOP   = 8'h00;
    localparam logic [7:0] ALU_SLTI  = 8'h01;
    localparam logic [7:0] ALU_SLTUI = 8'h02;
    localparam logic [7:0] ALU_ADDIW = 8'h03;
    localparam logic [7:0] ALU_ANDI  = 8'h04;
    localparam logic [7:0] ALU_ORI   = 8'h05;
    localparam logic [7:0] ALU_XORI  = 8'h06;
    localparam logic [7:0] ALU_LDB   = 8'h10;
    localparam logic [7:0] ALU_LDH   = 8'h11;
    localparam logic [7:0] ALU_LDW   = 8'h12;
    localparam logic [7:0] ALU_LDBU  = 8'h13;
    localparam logic [7:0] ALU_LDHU  = 8'h14;
    localparam logic [7:0] ALU_STB   = 8'h18;
    localparam logic [7:0] ALU_STH   = 8'h19;
    localparam logic [7:0] ALU_STW   = 8'h1a;
    localparam logic [7:0] ALU_ADDW  = 8'h20;
    localparam logic [7:0] ALU_SUBW  = 8'h21;
    localparam logic [7:0] ALU_SLT   = 8'h22;
    localparam logic [7:0] ALU_SLTU  = 8'h23;
    localparam logic [7:0] ALU_NOR   = 8'h24;
    localparam logic [7:0] ALU_AND   = 8'h25;
    localparam logic [7:0] ALU_OR    = 8'h26;
    localparam logic [7:0] ALU_XOR   = 8'h27;

    localparam logic [2:0] ALU_SEL_NOP        = 3'd0;
    localparam logic [2:0] ALU_SEL_ARITHMETIC = 3'd1;
    localparam logic [2:0] ALU_SEL_LOAD_STORE = 3'd2;

    localparam logic [5:0] EXC_INE = 6'h0d;

    // Control register map.
    localparam logic [1:0] CFG_CTRL       = 2'd0;
    localparam logic [1:0] CFG_DISPATCHED = 2'd1;
    localparam logic [1:0] CFG_ILLEGAL    = 2'd2;

    typedef union packed {
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] i12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_2ri12;
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_3r;
    } inst_word_u;

endpackage

//--- source/decoder_2ri12.sv
`timescale 1ns/1ps

module decoder_2ri12 (
    input  decode_pkg::inst_word_u inst_i,
    output logic                   match_o,
    output logic [7:0]             aluop_o,
    output logic [2:0]             alusel_o,
    output logic                   reg_write_en_o,
    output logic [1:0]             reg_read_en_o,
    output logic [4:0]             reg_read_addr0_o,
    output logic [4:0]             reg_read_addr1_o,
    output logic [31:0]            imm_o
);
    import decode_pkg::*;

    logic [31:0] simm;
    logic [31:0] uimm;

    assign simm = {{20{inst_i.fmt_2ri12.i12[11]}}, inst_i.fmt_2ri12.i12};
    assign uimm = {20'b0, inst_i.fmt_2ri12.i12};

    always_comb begin
        // Most opcodes read rj, write rd and take the signed offset.
        match_o          = 1'b1;
        aluop_o          = ALU_NOP;
        alusel_o         = ALU_SEL_ARITHMETIC;
        reg_write_en_o   = 1'b1;
        reg_read_en_o    = 2'b01;
        reg_read_addr0_o = inst_i.fmt_2ri12.rj;
        reg_read_addr1_o = 5'b0;
        imm_o            = simm;

        case (inst_i.fmt_2ri12.opcode)
            OP_SLTI:  aluop_o = ALU_SLTI;
            OP_SLTUI: aluop_o = ALU_SLTUI;
            OP_ADDIW: aluop_o = ALU_ADDIW;
            OP_ANDI: begin
                aluop_o = ALU_ANDI;
                imm_o   = uimm;
            end
            OP_ORI: begin
                aluop_o = ALU_ORI;
                imm_o   = uimm;
            end
            OP_XORI: begin
                aluop_o = ALU_XORI;
                imm_o   = uimm;
            end
            OP_LDB, OP_LDH, OP_LDW, OP_LDBU, OP_LDHU: begin
                alusel_o = ALU_SEL_LOAD_STORE;
                case (inst_i.fmt_2ri12.opcode)
                    OP_LDB:  aluop_o = ALU_LDB;
                    OP_LDH:  aluop_o = ALU_LDH;
                    OP_LDW:  aluop_o = ALU_LDW;
                    OP_LDBU: aluop_o = ALU_LDBU;
                    default: aluop_o = ALU_LDHU;
                endcase
            end
            OP_STB, OP_STH, OP_STW: begin
                // Store data comes from rd.
                alusel_o         = ALU_SEL_LOAD_STORE;
                reg_write_en_o   = 1'b0;
                reg_read_en_o    = 2'b11;
                reg_read_addr1_o = inst_i.fmt_2ri12.rd;
                case (inst_i.fmt_2ri12.opcode)
                    OP_STB:  aluop_o = ALU_STB;
                    OP_STH:  aluop_o = ALU_STH;
                    default: aluop_o = ALU_STW;
                endcase
            end
            default: begin
                match_o          = 1'b0;
                alusel_o         = ALU_SEL_NOP;
                reg_write_en_o   = 1'b0;
                reg_read_en_o    = 2'b00;
                reg_read_addr0_o = 5'b0;
                imm_o            = 32'b0;
            end
        endcase
    end

endmodule

//--- source/decoder_3r.sv
`timescale 1ns/1ps

module decoder_3r (
    input  decode_pkg::inst_word_u inst_i,
    output logic                   match_o,
    output logic [7:0]             aluop_o,
    output logic [2:0]             alusel_o,
    output logic                   reg_write_en_o,
    output logic [1:0]             reg_read_en_o,
    output logic [4:0]             reg_read_addr0_o,
    output logic [4:0]             reg_read_addr1_o,
    output logic [31:0]            imm_o
);
    import decode_pkg::*;

    // No immediate in this format.
    assign imm_o = 32'b0;

    always_comb begin
        match_o          = 1'b1;
        aluop_o          = ALU_NOP;
        alusel_o         = ALU_SEL_ARITHMETIC;
        reg_write_en_o   = 1'b1;
        reg_read_en_o    = 2'b11;
        reg_read_addr0_o = inst_i.fmt_3r.rj;
        reg_read_addr1_o = inst_i.fmt_3r.rk;

        case (inst_i.fmt_3r.opcode)
            OP_ADDW: aluop_o = ALU_ADDW;
            OP_SUBW: aluop_o = ALU_SUBW;
            OP_SLT:  aluop_o = ALU_SLT;
            OP_SLTU: aluop_o = ALU_SLTU;
            OP_NOR:  aluop_o = ALU_NOR;
            OP_AND:  aluop_o = ALU_AND;
            OP_OR:   aluop_o = ALU_OR;
            OP_XOR:  aluop_o = ALU_XOR;
            default: begin
                match_o          = 1'b0;
                alusel_o         = ALU_SEL_NOP;
                reg_write_en_o   = 1'b0;
                reg_read_en_o    = 2'b00;
                reg_read_addr0_o = 5'b0;
                reg_read_addr1_o = 5'b0;
            end
        endcase
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        inst_valid_i,
    output logic        inst_ready_o,
    input  logic [31:0] pc_i,
    input  logic [31:0] inst_i,
    input  logic        mem_en_i,
    output logic        dispatch_valid_o,
    input  logic        dispatch_ready_i,
    output logic [31:0] pc_o,
    output logic [31:0] inst_o,
    output logic [7:0]  aluop_o,
    output logic [2:0]  alusel_o,
    output logic        reg_write_en_o,
    output logic [4:0]  reg_write_addr_o,
    output logic [1:0]  reg_read_en_o,
    output logic [4:0]  reg_read_addr0_o,
    output logic [4:0]  reg_read_addr1_o,
    output logic [31:0] imm_o,
    output logic        is_exception_o,
    output logic [5:0]  exception_cause_o
);
    import decode_pkg::*;

    logic        m_ri, m_rr;
    logic [7:0]  op_ri, op_rr;
    logic [2:0]  sel_ri, sel_rr;
    logic        we_ri, we_rr;
    logic [1:0]  re_ri, re_rr;
    logic [4:0]  ra0_ri, ra0_rr;
    logic [4:0]  ra1_ri, ra1_rr;
    logic [31:0] imm_ri, imm_rr;

    logic        illegal;
    logic [7:0]  d_aluop;
    logic [2:0]  d_alusel;
    logic        d_we;
    logic [1:0]  d_re;
    logic [4:0]  d_ra0;
    logic [4:0]  d_ra1;
    logic [31:0] d_imm;
    logic        accept;

    decoder_2ri12 u_dec_2ri12 (
        .inst_i           (inst_i),
        .match_o          (m_ri),
        .aluop_o          (op_ri),
        .alusel_o         (sel_ri),
        .reg_write_en_o   (we_ri),
        .reg_read_en_o    (re_ri),
        .reg_read_addr0_o (ra0_ri),
        .reg_read_addr1_o (ra1_ri),
        .imm_o            (imm_ri)
    );

    decoder_3r u_dec_3r (
        .inst_i           (inst_i),
        .match_o          (m_rr),
        .aluop_o          (op_rr),
        .alusel_o         (sel_rr),
        .reg_write_en_o   (we_rr),
        .reg_read_en_o    (re_rr),
        .reg_read_addr0_o (ra0_rr),
        .reg_read_addr1_o (ra1_rr),
        .imm_o            (imm_rr)
    );

    // Opcode spaces are disjoint, so at most one decoder matches.
    assign illegal = !(m_ri || m_rr)
                     || (m_ri && sel_ri == ALU_SEL_LOAD_STORE && !mem_en_i);

    always_comb begin
        if (illegal) begin
            d_aluop  = ALU_NOP;
            d_alusel = ALU_SEL_NOP;
            d_we     = 1'b0;
            d_re     = 2'b00;
            d_ra0    = 5'b0;
            d_ra1    = 5'b0;
            d_imm    = 32'b0;
        end else if (m_ri) begin
            d_aluop  = op_ri;
            d_alusel = sel_ri;
            d_we     = we_ri;
            d_re     = re_ri;
            d_ra0    = ra0_ri;
            d_ra1    = ra1_ri;
            d_imm    = imm_ri;
        end else begin
            d_aluop  = op_rr;
            d_alusel = sel_rr;
            d_we     = we_rr;
            d_re     = re_rr;
            d_ra0    = ra0_rr;
            d_ra1    = ra1_rr;
            d_imm    = imm_rr;
        end
    end

    // Single output slot; refill when empty or draining.
    assign inst_ready_o = !dispatch_valid_o || dispatch_ready_i;
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dispatch_valid_o <= 1'b0;
        end else if (inst_ready_o) begin
            dispatch_valid_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_o              <= pc_i;
            inst_o            <= inst_i;
            aluop_o           <= d_aluop;
            alusel_o          <= d_alusel;
            reg_write_en_o    <= d_we;
            reg_write_addr_o  <= inst_i[4:0];
            reg_read_en_o     <= d_re;
            reg_read_addr0_o  <= d_ra0;
            reg_read_addr1_o  <= d_ra1;
            imm_o             <= d_imm;
            is_exception_o    <= illegal;
            exception_cause_o <= illegal ? EXC_INE : 6'b0;
        end
    end

endmodule

//--- source/decode_ctrl_regs.sv
`timescale 1ns/1ps

module decode_ctrl_regs (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        cfg_we_i,
    input  logic [1:0]  cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o,
    input  logic        dispatch_valid_i,
    input  logic        dispatch_ready_i,
    input  logic        is_exception_i,
    output logic        mem_en_o
);
    import decode_pkg::*;

    logic        mem_en;
    logic [31:0] dispatched_cnt;
    logic [31:0] illegal_cnt;
    logic        fire;

    assign fire     = dispatch_valid_i && dispatch_ready_i;
    assign mem_en_o = mem_en;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_en <= 1'b1;
        end else if (cfg_we_i && cfg_addr_i == CFG_CTRL) begin
            mem_en <= cfg_wdata_i[0];
        end
    end

    // Both counters wrap.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dispatched_cnt <= 32'b0;
            illegal_cnt    <= 32'b0;
        end else if (fire) begin
            dispatched_cnt <= dispatched_cnt + 32'd1;
            if (is_exception_i) begin
                illegal_cnt <= illegal_cnt + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            CFG_CTRL:       cfg_rdata_o = {31'b0, mem_en};
            CFG_DISPATCHED: cfg_rdata_o = dispatched_cnt;
            CFG_ILLEGAL:    cfg_rdata_o = illegal_cnt;
            default:        cfg_rdata_o = 32'b0;
        endcase
    end

endmodule

//--- source/decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        inst_valid_i,
    output logic        inst_ready_o,
    input  logic [31:0] pc_i,
    input  logic [31:0] inst_i,
    output logic        dispatch_valid_o,
    input  logic        dispatch_ready_i,
    output logic [31:0] pc_o,
    output logic [31:0] inst_o,
    output logic [7:0]  aluop_o,
    output logic [2:0]  alusel_o,
    output logic        reg_write_en_o,
    output logic [4:0]  reg_write_addr_o,
    output logic [1:0]  reg_read_en_o,
    output logic [4:0]  reg_read_addr0_o,
    output logic [4:0]  reg_read_addr1_o,
    output logic [31:0] imm_o,
    output logic        is_exception_o,
    output logic [5:0]  exception_cause_o,
    input  logic        cfg_we_i,
    input  logic [1:0]  cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] cfg_rdata_o
);

    logic mem_en;

    decode_stage u_stage (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .inst_valid_i      (inst_valid_i),
        .inst_ready_o      (inst_ready_o),
        .pc_i              (pc_i),
        .inst_i            (inst_i),
        .mem_en_i          (mem_en),
        .dispatch_valid_o  (dispatch_valid_o),
        .dispatch_ready_i  (dispatch_ready_i),
        .pc_o              (pc_o),
        .inst_o            (inst_o),
        .aluop_o           (aluop_o),
        .alusel_o          (alusel_o),
        .reg_write_en_o    (reg_write_en_o),
        .reg_write_addr_o  (reg_write_addr_o),
        .reg_read_en_o     (reg_read_en_o),
        .reg_read_addr0_o  (reg_read_addr0_o),
        .reg_read_addr1_o  (reg_read_addr1_o),
        .imm_o             (imm_o),
        .is_exception_o    (is_exception_o),
        .exception_cause_o (exception_cause_o)
    );

    // Counters watch the dispatch handshake.
    decode_ctrl_regs u_ctrl (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .cfg_we_i         (cfg_we_i),
        .cfg_addr_i       (cfg_addr_i),
        .cfg_wdata_i      (cfg_wdata_i),
        .cfg_rdata_o      (cfg_rdata_o),
        .dispatch_valid_i (dispatch_valid_o),
        .dispatch_ready_i (dispatch_ready_i),
        .is_exception_i   (is_exception_o),
        .mem_en_o         (mem_en)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held for three rising edges.
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- tb/decode_properties.sv
`timescale 1ns/1ps

module decode_properties (
    input logic        clk,
    input logic        rst_n_i,
    input logic        valid_i,
    input logic        ready_i,
    input logic [31:0] pc_i,
    input logic [31:0] inst_i,
    input logic [7:0]  aluop_i,
    input logic        write_en_i,
    input logic        exception_i
);
    import decode_pkg::*;

    // Stalled slot keeps its contents.
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i && !ready_i |=> valid_i && $stable(pc_i) && $stable(inst_i) && $stable(aluop_i))
        else $error("dispatch outputs changed under back-pressure");

    reset_idle: assert property (@(posedge clk) !rst_n_i |=> !valid_i)
        else $error("dispatch valid high after reset");

    exc_is_nop: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i && exception_i |-> aluop_i == ALU_NOP && !write_en_i)
        else $error("exception output is not a NOP");

endmodule

bind decode_stage decode_properties u_props (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (dispatch_valid_o),
    .ready_i     (dispatch_ready_i),
    .pc_i        (pc_o),
    .inst_i      (inst_o),
    .aluop_i     (aluop_o),
    .write_en_i  (reg_write_en_o),
    .exception_i (is_exception_o)
);

//--- tb/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;
    import decode_pkg::*;

    localparam int NUM_WORDS   = 600;
    localparam int MAX_STALL   = 16;
    localparam int CYCLE_LIMIT = NUM_WORDS * MAX_STALL + 100;

    // Index 0..5 ALU, 6..10 loads, 11..13 stores.
    localparam logic [9:0] RI_OPS [14] = '{OP_SLTI, OP_SLTUI, OP_ADDIW, OP_ANDI, OP_ORI,
        OP_XORI, OP_LDB, OP_LDH, OP_LDW, OP_LDBU, OP_LDHU, OP_STB, OP_STH, OP_STW};
    localparam logic [7:0] RI_ALU [14] = '{ALU_SLTI, ALU_SLTUI, ALU_ADDIW, ALU_ANDI, ALU_ORI,
        ALU_XORI, ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU, ALU_STB, ALU_STH, ALU_STW};
    localparam logic [16:0] RR_OPS [8] = '{OP_ADDW, OP_SUBW, OP_SLT, OP_SLTU, OP_NOR, OP_AND,
        OP_OR, OP_XOR};
    localparam logic [7:0] RR_ALU [8] = '{ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU, ALU_NOR,
        ALU_AND, ALU_OR, ALU_XOR};

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [7:0]  aluop;
        logic [2:0]  alusel;
        logic        we;
        logic [4:0]  wa;
        logic [1:0]  re;
        logic [4:0]  ra0;
        logic [4:0]  ra1;
        logic [31:0] imm;
        logic        exc;
    } exp_t;

    logic        clk, rst_n;
    logic        inst_valid_i, inst_ready_o, dispatch_valid_o, dispatch_ready_i;
    logic [31:0] pc_i, inst_i, pc_o, inst_o, imm_o, cfg_wdata_i, cfg_rdata_o;
    logic [7:0]  aluop_o;
    logic [2:0]  alusel_o;
    logic        reg_write_en_o, is_exception_o, cfg_we_i;
    logic [4:0]  reg_write_addr_o, reg_read_addr0_o, reg_read_addr1_o;
    logic [1:0]  reg_read_en_o, cfg_addr_i;
    logic [5:0]  exception_cause_o;

    logic [31:0] seed = 32'h69b3;
    exp_t        expq[$];
    logic        mem_en_model = 1'b1;
    logic        took = 1'b0;
    int          accepted = 0;
    int          dispatched = 0;
    int          illegal = 0;
    int          cycles = 0;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    decode_top uut (
        .clk(clk), .rst_n_i(rst_n), .inst_valid_i(inst_valid_i), .inst_ready_o(inst_ready_o),
        .pc_i(pc_i), .inst_i(inst_i), .dispatch_valid_o(dispatch_valid_o),
        .dispatch_ready_i(dispatch_ready_i), .pc_o(pc_o), .inst_o(inst_o), .aluop_o(aluop_o),
        .alusel_o(alusel_o), .reg_write_en_o(reg_write_en_o),
        .reg_write_addr_o(reg_write_addr_o), .reg_read_en_o(reg_read_en_o),
        .reg_read_addr0_o(reg_read_addr0_o), .reg_read_addr1_o(reg_read_addr1_o),
        .imm_o(imm_o), .is_exception_o(is_exception_o), .exception_cause_o(exception_cause_o),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
        .cfg_rdata_o(cfg_rdata_o)
    );

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    // Half table opcodes, a quarter 3R, a quarter fully random.
    function automatic logic [31:0] gen_word();
        logic [31:0] r;
        logic [31:0] kind;
        logic [3:0]  ri;
        logic [2:0]  rr;
        r    = rand32();
        kind = rand32() % 8;
        ri   = 4'(rand32() % 14);
        rr   = 3'(rand32());
        if (kind < 4) begin
            return {RI_OPS[ri], r[21:0]};
        end else if (kind < 6) begin
            return {RR_OPS[rr], r[14:0]};
        end
        return r;
    endfunction

    function automatic exp_t model_decode(input logic [31:0] pc, input logic [31:0] w,
                                          input logic mem_en);
        exp_t       e;
        logic [3:0] k;
        e        = '0;
        e.pc     = pc;
        e.inst   = w;
        e.wa     = w[4:0];
        e.aluop  = ALU_NOP;
        e.alusel = ALU_SEL_NOP;
        e.exc    = 1'b1;
        for (k = 4'd0; k < 4'd14; k++) begin
            if (w[31:22] == RI_OPS[k] && (k < 4'd6 || mem_en)) begin
                e.exc    = 1'b0;
                e.aluop  = RI_ALU[k];
                e.alusel = (k >= 4'd6) ? ALU_SEL_LOAD_STORE : ALU_SEL_ARITHMETIC;
                e.we     = (k < 4'd11);
                e.re     = (k >= 4'd11) ? 2'b11 : 2'b01;
                e.ra0    = w[9:5];
                e.ra1    = (k >= 4'd11) ? w[4:0] : 5'd0;
                e.imm    = (k >= 4'd3 && k <= 4'd5) ? {20'd0, w[21:10]}
                                                    : {{20{w[21]}}, w[21:10]};
            end
        end
        for (k = 4'd0; k < 4'd8; k++) begin
            if (w[31:15] == RR_OPS[k[2:0]]) begin
                e.exc    = 1'b0;
                e.aluop  = RR_ALU[k[2:0]];
                e.alusel = ALU_SEL_ARITHMETIC;
                e.we     = 1'b1;
                e.re     = 2'b11;
                e.ra0    = w[9:5];
                e.ra1    = w[14:10];
            end
        end
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        $display("Regression failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic check_decode(input exp_t e);
        if (pc_o !== e.pc) report_mismatch("pc_o", pc_o, e.pc);
        if (inst_o !== e.inst) report_mismatch("inst_o", inst_o, e.inst);
        if (aluop_o !== e.aluop) report_mismatch("aluop_o", 32'(aluop_o), 32'(e.aluop));
        if (alusel_o !== e.alusel) report_mismatch("alusel_o", 32'(alusel_o), 32'(e.alusel));
        if (reg_write_en_o !== e.we) begin
            report_mismatch("reg_write_en_o", 32'(reg_write_en_o), 32'(e.we));
        end
        if (reg_write_addr_o !== e.wa) begin
            report_mismatch("reg_write_addr_o", 32'(reg_write_addr_o), 32'(e.wa));
        end
        if (reg_read_en_o !== e.re) begin
            report_mismatch("reg_read_en_o", 32'(reg_read_en_o), 32'(e.re));
        end
        if (reg_read_addr0_o !== e.ra0) begin
            report_mismatch("reg_read_addr0_o", 32'(reg_read_addr0_o), 32'(e.ra0));
        end
        if (reg_read_addr1_o !== e.ra1) begin
            report_mismatch("reg_read_addr1_o", 32'(reg_read_addr1_o), 32'(e.ra1));
        end
        if (imm_o !== e.imm) report_mismatch("imm_o", imm_o, e.imm);
    endtask

    task automatic check_exception(input logic exp_exc);
        if (is_exception_o !== exp_exc) begin
            report_mismatch("is_exception_o", 32'(is_exception_o), 32'(exp_exc));
        end
        if (exp_exc && exception_cause_o !== EXC_INE) begin
            report_mismatch("exception_cause_o", 32'(exception_cause_o), 32'(EXC_INE));
        end
    endtask

    task automatic check_reg(input logic [1:0] addr, input logic [31:0] exp);
        cfg_addr_i = addr;
        #1;
        if (cfg_rdata_o !== exp) begin
            report_mismatch($sformatf("cfg_rdata_o[%0d]", addr), cfg_rdata_o, exp);
        end
    endtask

    // Turns memory ops off for the middle third of the words.
    task automatic drive_inputs();
        cfg_we_i = 1'b0;
        if (accepted >= NUM_WORDS / 3 && accepted < 2 * NUM_WORDS / 3) begin
            cfg_we_i    = mem_en_model;
            cfg_wdata_i = 32'd0;
        end else if (accepted >= 2 * NUM_WORDS / 3) begin
            cfg_we_i    = !mem_en_model;
            cfg_wdata_i = 32'd1;
        end
        dispatch_ready_i = (rand32() % 4) != 0;
        if (!inst_valid_i || took) begin
            inst_valid_i = (accepted < NUM_WORDS) && ((rand32() % 4) != 0);
            if (inst_valid_i) begin
                inst_i = gen_word();
                pc_i   = pc_i + 32'd4;
            end
        end
    endtask

    task automatic sample_outputs();
        exp_t e;
        took = inst_valid_i && inst_ready_o;
        if (dispatch_valid_o && dispatch_ready_i) begin
            if (expq.size() == 0) begin
                $display("Regression failed");
                $fatal(1, "dispatch handshake with no accepted word outstanding");
            end
            e = expq.pop_front();
            check_decode(e);
            check_exception(e.exc);
            dispatched++;
            if (e.exc) illegal++;
        end
        if (took) begin
            expq.push_back(model_decode(pc_i, inst_i, mem_en_model));
            accepted++;
        end
        if (cfg_we_i && cfg_addr_i == CFG_CTRL) mem_en_model = cfg_wdata_i[0];
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Regression failed");
            $fatal(1, "run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    initial begin
        inst_valid_i     = 1'b0;
        pc_i             = 32'h1c00_0000;
        inst_i           = 32'b0;
        dispatch_ready_i = 1'b0;
        cfg_we_i         = 1'b0;
        cfg_addr_i       = CFG_CTRL;
        cfg_wdata_i      = 32'b0;
        wait (rst_n);
        if (dispatch_valid_o !== 1'b0) begin
            report_mismatch("dispatch_valid_o", 32'(dispatch_valid_o), 0);
        end
        if (inst_ready_o !== 1'b1) report_mismatch("inst_ready_o", 32'(inst_ready_o), 1);
        check_reg(CFG_DISPATCHED, 32'd0);
        check_reg(CFG_ILLEGAL, 32'd0);
        check_reg(CFG_CTRL, 32'd1);
        while (accepted < NUM_WORDS || expq.size() != 0) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end
        @(posedge clk);
        #1;
        cfg_we_i = 1'b0;
        check_reg(CFG_DISPATCHED, 32'(dispatched));
        check_reg(CFG_ILLEGAL, 32'(illegal));
        check_reg(CFG_CTRL, 32'd1);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- filelist.f
source/decode_pkg.sv
source/decoder_2ri12.sv
source/decoder_3r.sv
source/decode_stage.sv
source/decode_ctrl_regs.sv
source/decode_top.sv
tb/tb_clock_gen.sv
tb/decode_properties.sv
tb/decode_tb.sv

//--- run.sh
#!/bin/sh
# Builds the decode testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module decode_tb \
    -Mdir obj_dir \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vdecode_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi
exit 0
